/* build.f */
hdl/mem_pkg.sv
hdl/mem_issue.sv
hdl/ram_arbiter.sv
hdl/data_ram.sv
hdl/mem_finish.sv
hdl/mem_top.sv
tb/tb_mem_top.sv

/* hdl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int unsigned ram_words = 1024
) (
    input  wire logic                          clk,
    input  wire logic                          en_i,
    input  wire logic                          we_i,
    input  wire logic [$clog2(ram_words)-1:0]  addr_i,
    input  wire logic [3:0]                    be_i,
    input  wire mem_pkg::word_t                wdata_i,
    output mem_pkg::word_t                     rdata_o
);
    import mem_pkg::*;

    word_t mem [ram_words];

    // each byte lane is written on its own enable.
    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (be_i[lane]) begin
                    mem[addr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
                end
            end
        end
    end

    // Reads are registered and the output keeps its value between reads.
    always_ff @(posedge clk) begin
        if (en_i && !we_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_finish.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_finish (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               stall_i,
    input  wire logic               flush_i,
    output logic                    stall_o,
    input  wire logic               iss_valid_i,
    input  wire mem_pkg::op_kind_t  iss_kind_i,
    input  wire mem_pkg::size_t     iss_size_i,
    input  wire logic               iss_signed_i,
    input  wire logic [1:0]         iss_lane_i,
    input  wire mem_pkg::word_t     iss_ex_out_i,
    input  wire mem_pkg::word_t     iss_pc_plus4_i,
    input  wire mem_pkg::reg_idx_t  iss_rd_i,
    input  wire mem_pkg::word_t     rdata_i,
    input  wire logic               rdata_valid_i,
    output logic                    wb_valid_o,
    output mem_pkg::reg_idx_t       wb_rd_o,
    output mem_pkg::word_t          wb_data_o,
    output logic                    fwd_valid_o,
    output mem_pkg::reg_idx_t       fwd_idx_o,
    output mem_pkg::word_t          fwd_data_o,
    output logic                    fwd_data_valid_o
);
    import mem_pkg::*;

    logic         valid_q;
    op_kind_t     kind_q;
    size_t        size_q;
    logic         signed_q;
    logic [1:0]   lane_q;
    word_t        ex_out_q;
    word_t        pc_plus4_q;
    reg_idx_t     rd_q;
    logic         seen_q;
    word_t        data_q;
    logic         is_load;
    logic         data_here;
    word_t        ld_word;
    logic [7:0]   ld_byte;
    logic [15:0]  ld_half;
    word_t        ld_ext;
    word_t        wb_value;

    assign is_load   = valid_q && (kind_q == op_load);
    assign data_here = !is_load || seen_q || rdata_valid_i;
    assign stall_o   = stall_i || !data_here;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            seen_q  <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
            seen_q  <= 1'b0;
        end else if (!stall_o) begin
            valid_q <= iss_valid_i;
            seen_q  <= 1'b0;
        end else if (rdata_valid_i) begin
            // load data came in while stall_i holds the stage.
            seen_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (flush_i || !stall_o) begin
            kind_q     <= iss_kind_i;
            size_q     <= iss_size_i;
            signed_q   <= iss_signed_i;
            lane_q     <= iss_lane_i;
            ex_out_q   <= iss_ex_out_i;
            pc_plus4_q <= iss_pc_plus4_i;
            rd_q       <= iss_rd_i;
        end
        // the RAM output may be overwritten by a debug read, so keep a copy.
        if (rdata_valid_i) begin
            data_q <= rdata_i;
        end
    end

    assign ld_word = seen_q ? data_q : rdata_i;
    assign ld_byte = ld_word[lane_q*8 +: 8];
    assign ld_half = lane_q[1] ? ld_word[31:16] : ld_word[15:0];

    always_comb begin
        unique case (size_q)
            size_byte: ld_ext = {{24{signed_q & ld_byte[7]}}, ld_byte};
            size_half: ld_ext = {{16{signed_q & ld_half[15]}}, ld_half};
            default:   ld_ext = ld_word;
        endcase
    end

    always_comb begin
        unique case (kind_q)
            op_load: wb_value = ld_ext;
            op_link: wb_value = pc_plus4_q;
            default: wb_value = ex_out_q;
        endcase
    end

    assign wb_valid_o = valid_q && (kind_q != op_store) && !stall_o && !flush_i;
    assign wb_rd_o    = rd_q;
    assign wb_data_o  = wb_value;

    // Earlier stages see the held result; a pending load asks them to wait.
    assign fwd_valid_o      = valid_q && (kind_q != op_store) && (rd_q != '0);
    assign fwd_idx_o        = rd_q;
    assign fwd_data_o       = wb_value;
    assign fwd_data_valid_o = data_here;

    // the issue stage only sends a read along with the load that wants it.
    rvalid_needs_load: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid_i |-> is_load);

endmodule

`default_nettype wire

/* hdl/mem_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_issue (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        op_valid_i,
    input  wire mem_pkg::op_kind_t           op_kind_i,
    input  wire mem_pkg::size_t              op_size_i,
    input  wire logic                        op_signed_i,
    input  wire logic [mem_pkg::addr_w-1:0]  op_addr_i,
    input  wire mem_pkg::word_t              op_wdata_i,
    input  wire mem_pkg::word_t              op_ex_out_i,
    input  wire mem_pkg::word_t              op_pc_plus4_i,
    input  wire mem_pkg::reg_idx_t           op_rd_i,
    input  wire logic                        flush_i,
    input  wire logic                        finish_stall_i,
    input  wire logic                        pipe_gnt_i,
    output logic                             stall_o,
    output logic                             pipe_req_o,
    output logic                             pipe_we_o,
    output logic [mem_pkg::addr_w-3:0]       pipe_word_addr_o,
    output logic [3:0]                       pipe_be_o,
    output mem_pkg::word_t                   pipe_wdata_o,
    output logic                             iss_valid_o,
    output mem_pkg::op_kind_t                iss_kind_o,
    output mem_pkg::size_t                   iss_size_o,
    output logic                             iss_signed_o,
    output logic [1:0]                       iss_lane_o,
    output mem_pkg::word_t                   iss_ex_out_o,
    output mem_pkg::word_t                   iss_pc_plus4_o,
    output mem_pkg::reg_idx_t                iss_rd_o
);
    import mem_pkg::*;

    logic                valid_q;
    op_kind_t            kind_q;
    size_t               size_q;
    logic                signed_q;
    logic [addr_w-1:0]   addr_q;
    word_t               wdata_q;
    word_t               ex_out_q;
    word_t               pc_plus4_q;
    reg_idx_t            rd_q;
    logic                is_mem;

    assign is_mem = valid_q && (kind_q == op_load || kind_q == op_store);

    // the stage holds while the finish stage is busy or the RAM port went elsewhere.
    assign stall_o = valid_q && (finish_stall_i || (is_mem && !pipe_gnt_i));

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_o) begin
            valid_q <= op_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            kind_q     <= op_kind_i;
            size_q     <= op_size_i;
            signed_q   <= op_signed_i;
            addr_q     <= op_addr_i;
            wdata_q    <= op_wdata_i;
            ex_out_q   <= op_ex_out_i;
            pc_plus4_q <= op_pc_plus4_i;
            rd_q       <= op_rd_i;
        end
    end

    // Only ask for the RAM when the finish stage can take the result next edge.
    assign pipe_req_o       = is_mem && !finish_stall_i && !flush_i;
    assign pipe_we_o        = (kind_q == op_store);
    assign pipe_word_addr_o = addr_q[addr_w-1:2];

    always_comb begin
        unique case (size_q)
            size_byte: begin
                pipe_be_o    = 4'b0001 << addr_q[1:0];
                pipe_wdata_o = {4{wdata_q[7:0]}};
            end
            size_half: begin
                pipe_be_o    = addr_q[1] ? 4'b1100 : 4'b0011;
                pipe_wdata_o = {2{wdata_q[15:0]}};
            end
            size_word: begin
                pipe_be_o    = 4'b1111;
                pipe_wdata_o = wdata_q;
            end
            default: begin
                pipe_be_o    = 4'b0000;
                pipe_wdata_o = wdata_q;
            end
        endcase
    end

    assign iss_valid_o    = valid_q && !stall_o;
    assign iss_kind_o     = kind_q;
    assign iss_size_o     = size_q;
    assign iss_signed_o   = signed_q;
    assign iss_lane_o     = addr_q[1:0];
    assign iss_ex_out_o   = ex_out_q;
    assign iss_pc_plus4_o = pc_plus4_q;
    assign iss_rd_o       = rd_q;

    // a store must reach the RAM with at least one byte lane enabled.
    store_has_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        pipe_req_o && pipe_we_o |-> pipe_be_o != 4'b0000);

endmodule

`default_nettype wire

/* hdl/mem_pkg.sv */
`default_nettype none

// Shared types for the memory back end of the pipeline.
package mem_pkg;

    // width of a byte address; 12 bits cover 4 KiB of data memory.
    localparam int addr_w = 12;

    // one data word as it moves through the memory stages.
    typedef logic [31:0] word_t;

    // Access size of a load or store.
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_t;

    // Operation kind.
    // op_alu and op_link bypass memory and only pick their writeback value.
    typedef enum logic [1:0] {
        op_alu   = 2'd0,
        op_link  = 2'd1,
        op_load  = 2'd2,
        op_store = 2'd3
    } op_kind_t;

    // destination register index into the 32-entry register file.
    typedef logic [4:0] reg_idx_t;

endpackage

`default_nettype wire

/* hdl/mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_top #(
    parameter int unsigned ram_words = 1024
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        op_valid_i,
    input  wire mem_pkg::op_kind_t           op_kind_i,
    input  wire mem_pkg::size_t              op_size_i,
    input  wire logic                        op_signed_i,
    input  wire logic [mem_pkg::addr_w-1:0]  op_addr_i,
    input  wire mem_pkg::word_t              op_wdata_i,
    input  wire mem_pkg::word_t              op_ex_out_i,
    input  wire mem_pkg::word_t              op_pc_plus4_i,
    input  wire mem_pkg::reg_idx_t           op_rd_i,
    input  wire logic                        stall_i,
    input  wire logic                        flush_i,
    output logic                             stall_o,
    output logic                             wb_valid_o,
    output mem_pkg::reg_idx_t                wb_rd_o,
    output mem_pkg::word_t                   wb_data_o,
    output logic                             fwd_valid_o,
    output mem_pkg::reg_idx_t                fwd_idx_o,
    output mem_pkg::word_t                   fwd_data_o,
    output logic                             fwd_data_valid_o,
    input  wire logic                        dbg_req_i,
    input  wire logic                        dbg_we_i,
    input  wire logic [mem_pkg::addr_w-3:0]  dbg_addr_i,  // word address
    input  wire mem_pkg::word_t              dbg_wdata_i,
    output logic                             dbg_gnt_o,
    output mem_pkg::word_t                   dbg_rdata_o,
    output logic                             dbg_rvalid_o
);
    import mem_pkg::*;

    logic               finish_stall;
    logic               pipe_req;
    logic               pipe_we;
    logic [addr_w-3:0]  pipe_word_addr;
    logic [3:0]         pipe_be;
    word_t              pipe_wdata;
    logic               pipe_gnt;
    logic               pipe_rvalid;
    logic               iss_valid;
    op_kind_t           iss_kind;
    size_t              iss_size;
    logic               iss_signed;
    logic [1:0]         iss_lane;
    word_t              iss_ex_out;
    word_t              iss_pc_plus4;
    reg_idx_t           iss_rd;
    logic               ram_en;
    logic               ram_we;
    logic [addr_w-3:0]  ram_addr;
    logic [3:0]         ram_be;
    word_t              ram_wdata;
    word_t              ram_rdata;

    mem_issue u_issue (
        .clk, .rst_n,
        .op_valid_i, .op_kind_i, .op_size_i, .op_signed_i, .op_addr_i,
        .op_wdata_i, .op_ex_out_i, .op_pc_plus4_i, .op_rd_i,
        .flush_i, .finish_stall_i(finish_stall), .pipe_gnt_i(pipe_gnt), .stall_o,
        .pipe_req_o(pipe_req), .pipe_we_o(pipe_we), .pipe_word_addr_o(pipe_word_addr),
        .pipe_be_o(pipe_be), .pipe_wdata_o(pipe_wdata),
        .iss_valid_o(iss_valid), .iss_kind_o(iss_kind), .iss_size_o(iss_size),
        .iss_signed_o(iss_signed), .iss_lane_o(iss_lane), .iss_ex_out_o(iss_ex_out),
        .iss_pc_plus4_o(iss_pc_plus4), .iss_rd_o(iss_rd)
    );

    mem_finish u_finish (
        .clk, .rst_n, .stall_i, .flush_i, .stall_o(finish_stall),
        .iss_valid_i(iss_valid), .iss_kind_i(iss_kind), .iss_size_i(iss_size),
        .iss_signed_i(iss_signed), .iss_lane_i(iss_lane), .iss_ex_out_i(iss_ex_out),
        .iss_pc_plus4_i(iss_pc_plus4), .iss_rd_i(iss_rd),
        .rdata_i(ram_rdata), .rdata_valid_i(pipe_rvalid),
        .wb_valid_o, .wb_rd_o, .wb_data_o,
        .fwd_valid_o, .fwd_idx_o, .fwd_data_o, .fwd_data_valid_o
    );

    ram_arbiter u_arbiter (
        .clk, .rst_n,
        .pipe_req_i(pipe_req), .pipe_we_i(pipe_we), .pipe_addr_i(pipe_word_addr),
        .pipe_be_i(pipe_be), .pipe_wdata_i(pipe_wdata),
        .pipe_gnt_o(pipe_gnt), .pipe_rvalid_o(pipe_rvalid),
        .dbg_req_i, .dbg_we_i, .dbg_addr_i, .dbg_wdata_i, .dbg_gnt_o, .dbg_rvalid_o,
        .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_addr_o(ram_addr),
        .ram_be_o(ram_be), .ram_wdata_o(ram_wdata)
    );

    data_ram #(
        .ram_words(ram_words)
    ) u_ram (
        .clk, .en_i(ram_en), .we_i(ram_we), .addr_i(ram_addr[$clog2(ram_words)-1:0]),
        .be_i(ram_be), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
    );

    // both requesters share the registered RAM output.
    assign dbg_rdata_o = ram_rdata;

endmodule

`default_nettype wire

/* hdl/ram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        pipe_req_i,
    input  wire logic                        pipe_we_i,
    input  wire logic [mem_pkg::addr_w-3:0]  pipe_addr_i,
    input  wire logic [3:0]                  pipe_be_i,
    input  wire mem_pkg::word_t              pipe_wdata_i,
    output logic                             pipe_gnt_o,
    output logic                             pipe_rvalid_o,
    input  wire logic                        dbg_req_i,
    input  wire logic                        dbg_we_i,
    input  wire logic [mem_pkg::addr_w-3:0]  dbg_addr_i,
    input  wire mem_pkg::word_t              dbg_wdata_i,
    output logic                             dbg_gnt_o,
    output logic                             dbg_rvalid_o,
    output logic                             ram_en_o,
    output logic                             ram_we_o,
    output logic [mem_pkg::addr_w-3:0]       ram_addr_o,
    output logic [3:0]                       ram_be_o,
    output mem_pkg::word_t                   ram_wdata_o
);

    // high when the debug port won the most recent grant.
    logic last_dbg_q;
    logic pipe_rd_q;
    logic dbg_rd_q;

    // on contention the requester that lost last time gets the port.
    assign pipe_gnt_o = pipe_req_i && (!dbg_req_i || last_dbg_q);
    assign dbg_gnt_o  = dbg_req_i && (!pipe_req_i || !last_dbg_q);

    assign ram_en_o    = pipe_gnt_o || dbg_gnt_o;
    assign ram_we_o    = dbg_gnt_o ? dbg_we_i : pipe_we_i;
    assign ram_addr_o  = dbg_gnt_o ? dbg_addr_i : pipe_addr_i;
    assign ram_be_o    = dbg_gnt_o ? 4'b1111 : pipe_be_i;   // debug writes are whole words.
    assign ram_wdata_o = dbg_gnt_o ? dbg_wdata_i : pipe_wdata_i;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            last_dbg_q <= 1'b0;
            pipe_rd_q  <= 1'b0;
            dbg_rd_q   <= 1'b0;
        end else begin
            if (ram_en_o) begin
                last_dbg_q <= dbg_gnt_o;
            end
            // remember whose read is in flight so the data-valid goes back to it.
            pipe_rd_q <= pipe_gnt_o && !pipe_we_i;
            dbg_rd_q  <= dbg_gnt_o && !dbg_we_i;
        end
    end

    assign pipe_rvalid_o = pipe_rd_q;
    assign dbg_rvalid_o  = dbg_rd_q;

    // a requester that loses on contention is served at the next edge if it still asks.
    pipe_waits_once: assert property (@(posedge clk) disable iff (!rst_n)
        pipe_req_i && !pipe_gnt_o |=> !pipe_req_i || pipe_gnt_o);

    dbg_waits_once: assert property (@(posedge clk) disable iff (!rst_n)
        dbg_req_i && !dbg_gnt_o |=> !dbg_req_i || dbg_gnt_o);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_mem_top -o Vtb_mem_top

output="$(./obj_dir/Vtb_mem_top 2>&1 || true)"
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi

/* tb/mem_stim.txt */
# W word_addr data | R word_addr expected | S random_on
# P and F: kind size signed byte_addr wdata ex_out pc_plus4 rd expected (F has no expected)
W 000 f1e203c4
W 001 7ffe8001
W 002 11223344
R 000 f1e203c4
R 001 7ffe8001
R 002 11223344
P 2 0 1 000 0 0 0 01 ffffffc4
P 2 0 0 000 0 0 0 02 000000c4
P 2 0 1 001 0 0 0 03 00000003
P 2 0 0 001 0 0 0 04 00000003
P 2 0 1 002 0 0 0 05 ffffffe2
P 2 0 0 002 0 0 0 06 000000e2
P 2 0 1 003 0 0 0 07 fffffff1
P 2 0 0 003 0 0 0 08 000000f1
P 2 1 1 004 0 0 0 09 ffff8001
P 2 1 0 004 0 0 0 0a 00008001
P 2 1 1 006 0 0 0 0b 00007ffe
P 2 1 0 006 0 0 0 0c 00007ffe
P 2 2 0 000 0 0 0 0d f1e203c4
P 0 2 0 000 0 12345678 0 05 12345678
P 1 2 0 000 0 deadbeef 00000104 07 00000104
P 0 2 0 000 0 00000055 0 00 00000055
P 3 0 0 009 000000a5 0 0 00 0
P 3 1 0 00a 0000beef 0 0 00 0
P 3 2 0 00c cafef00d 0 0 00 0
R 002 beefa544
R 003 cafef00d
S 1
P 2 2 0 000 0 0 0 11 f1e203c4
P 0 2 0 000 0 00000a01 0 12 00000a01
P 2 0 1 00a 0 0 0 13 ffffffef
P 1 2 0 000 0 0 00000208 14 00000208
P 2 1 0 00e 0 0 0 15 0000cafe
P 0 2 0 000 0 00000b02 0 00 00000b02
S 0
F 2 2 0 000 0 0 0 16
P 0 2 0 000 0 00000c03 0 17 00000c03

/* tb/tb_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_top;
    import mem_pkg::*;

    logic                clk;
    logic                rst_n;
    logic                op_valid_i;
    op_kind_t            op_kind_i;
    size_t               op_size_i;
    logic                op_signed_i;
    logic [addr_w-1:0]   op_addr_i;
    word_t               op_wdata_i;
    word_t               op_ex_out_i;
    word_t               op_pc_plus4_i;
    reg_idx_t            op_rd_i;
    logic                stall_i;
    logic                flush_i;
    logic                stall_o;
    logic                wb_valid_o;
    reg_idx_t            wb_rd_o;
    word_t               wb_data_o;
    logic                fwd_valid_o;
    reg_idx_t            fwd_idx_o;
    word_t               fwd_data_o;
    logic                fwd_data_valid_o;
    logic                dbg_req_i;
    logic                dbg_we_i;
    logic [addr_w-3:0]   dbg_addr_i;
    word_t               dbg_wdata_i;
    logic                dbg_gnt_o;
    word_t               dbg_rdata_o;
    logic                dbg_rvalid_o;

    // stimulus records as read from the file; every record has up to nine fields.
    logic [7:0]   cmd_mem [256];
    logic [31:0]  fld_mem [256][9];
    int           n_rec;
    int           cycles;
    int           limit;
    int           err_count;
    logic         rand_mode;
    logic [31:0]  seed;
    reg_idx_t     exp_rd_q [$];
    word_t        exp_data_q [$];

    mem_top #(.ram_words(1024)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string msg);
        err_count++;
        $display("Error at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic abort_run(input string reason);
        err_count++;
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_fwd(input reg_idx_t got_idx, input word_t got_data,
                             input reg_idx_t exp_idx, input word_t exp_data,
                             input string what);
        if (got_idx !== exp_idx || got_data !== exp_data) begin
            report_mismatch($sformatf("%s shows x%0d=%h, expected x%0d=%h",
                                      what, got_idx, got_data, exp_idx, exp_data));
        end
    endtask

    // random stalls and debug reads that fight the pipeline for the RAM.
    task automatic step_random();
        if (rand_mode) begin
            seed       = lcg_next(seed);
            stall_i    = (seed[31:30] == 2'b11);
            dbg_req_i  = seed[29];
            dbg_we_i   = 1'b0;
            dbg_addr_i = seed[27:18];
        end else begin
            stall_i   = 1'b0;
            dbg_req_i = 1'b0;
        end
    endtask

    task automatic drain();
        @(negedge clk);
        op_valid_i = 1'b0;
        stall_i    = 1'b0;
        dbg_req_i  = 1'b0;
        while (exp_data_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic dbg_write(input logic [31:0] addr, input word_t data);
        @(negedge clk);
        dbg_req_i   = 1'b1;
        dbg_we_i    = 1'b1;
        dbg_addr_i  = addr[addr_w-3:0];
        dbg_wdata_i = data;
        #1;
        while (!dbg_gnt_o) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        dbg_req_i = 1'b0;
    endtask

    task automatic dbg_read(input logic [31:0] addr, input word_t exp);
        @(negedge clk);
        dbg_req_i  = 1'b1;
        dbg_we_i   = 1'b0;
        dbg_addr_i = addr[addr_w-3:0];
        #1;
        while (!dbg_gnt_o) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        dbg_req_i = 1'b0;
        if (!dbg_rvalid_o) begin
            abort_run("a granted debug read returned no read-valid pulse");
        end
        check_word(dbg_rdata_o, exp, $sformatf("debug read of word %h", addr));
        @(negedge clk);
        if (dbg_rvalid_o) begin
            abort_run("a debug read returned more than one read-valid pulse");
        end
    endtask

    task automatic drive_op(input int r);
        op_valid_i    = 1'b1;
        op_kind_i     = op_kind_t'(fld_mem[r][0][1:0]);
        op_size_i     = size_t'(fld_mem[r][1][1:0]);
        op_signed_i   = fld_mem[r][2][0];
        op_addr_i     = fld_mem[r][3][addr_w-1:0];
        op_wdata_i    = fld_mem[r][4];
        op_ex_out_i   = fld_mem[r][5];
        op_pc_plus4_i = fld_mem[r][6];
        op_rd_i       = fld_mem[r][7][4:0];
    endtask

    task automatic send_op(input int r);
        @(negedge clk);
        step_random();
        drive_op(r);
        #1;
        while (stall_o) begin
            @(negedge clk);
            step_random();
            #1;
        end
        // the operation is taken at the coming rising edge.
        if (op_kind_i != op_store) begin
            exp_rd_q.push_back(op_rd_i);
            exp_data_q.push_back(fld_mem[r][8]);
        end
    endtask

    task automatic flush_op(input int r);
        drain();
        @(negedge clk);
        drive_op(r);
        #1;
        if (stall_o) begin
            abort_run("the pipeline stalled an operation meant for the flush test");
        end
        @(negedge clk);
        op_valid_i = 1'b0;
        flush_i    = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        drain();
    endtask

    // writebacks are compared in order against the scoreboard, late in each cycle.
    always begin
        reg_idx_t  exp_rd;
        word_t     exp_data;
        @(negedge clk);
        #40;
        if (rst_n) begin
            if (stall_i && wb_valid_o) begin
                abort_run("a writeback was signalled while stall_i was high");
            end
            if (wb_valid_o) begin
                if (exp_data_q.size() == 0) begin
                    abort_run("the DUT wrote back a result that no operation asked for");
                end
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                check_word(wb_data_o, exp_data, "writeback data");
                check_fwd(wb_rd_o, wb_data_o, exp_rd, exp_data, "writeback port");
                if (exp_rd == '0) begin
                    if (fwd_valid_o) begin
                        abort_run("forwarding was raised for register 0");
                    end
                end else begin
                    if (!fwd_valid_o || !fwd_data_valid_o) begin
                        abort_run("forwarding was not valid for a finished result");
                    end
                    check_fwd(fwd_idx_o, fwd_data_o, exp_rd, exp_data, "forward port");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            abort_run("the run took more cycles than the stimulus allows");
        end
    end

    initial begin
        int          fd;
        int          code;
        int          nf;
        logic [7:0]  c;
        string       line;
        rst_n         = 1'b0;
        op_valid_i    = 1'b0;
        op_kind_i     = op_alu;
        op_size_i     = size_word;
        op_signed_i   = 1'b0;
        op_addr_i     = '0;
        op_wdata_i    = '0;
        op_ex_out_i   = '0;
        op_pc_plus4_i = '0;
        op_rd_i       = '0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        dbg_req_i     = 1'b0;
        dbg_we_i      = 1'b0;
        dbg_addr_i    = '0;
        dbg_wdata_i   = '0;
        cycles        = 0;
        limit         = 0;
        err_count     = 0;
        n_rec         = 0;
        rand_mode     = 1'b0;
        seed          = 32'h3b02;
        fd = $fopen("tb/mem_stim.txt", "r");
        if (fd == 0) begin
            abort_run("the stimulus file tb/mem_stim.txt could not be opened");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", c);
            if (code != 1) begin
                break;
            end
            if (c == "#") begin
                code = $fgets(line, fd);
                continue;
            end
            case (c)
                "W", "R": nf = 2;
                "P":      nf = 9;
                "F":      nf = 8;
                "S":      nf = 1;
                default:  abort_run($sformatf("unknown stimulus command %c", c));
            endcase
            cmd_mem[n_rec] = c;
            for (int i = 0; i < nf; i++) begin
                code = $fscanf(fd, "%h", fld_mem[n_rec][i]);
            end
            n_rec++;
        end
        $fclose(fd);
        limit = 40 * n_rec + 200;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        if (stall_o || wb_valid_o || fwd_valid_o || dbg_gnt_o || dbg_rvalid_o) begin
            abort_run("an output was not low after reset");
        end

        for (int r = 0; r < n_rec; r++) begin
            case (cmd_mem[r])
                "W": begin
                    drain();
                    dbg_write(fld_mem[r][0], fld_mem[r][1]);
                end
                "R": begin
                    drain();
                    dbg_read(fld_mem[r][0], fld_mem[r][1]);
                end
                "P": send_op(r);
                "F": flush_op(r);
                default: rand_mode = fld_mem[r][0][0];
            endcase
        end
        drain();

        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
